// ==== flist.f ====
lau_pkg.sv
prefix_and_or.sv
add_cfast.sv
req_port.sv
rr_arbiter.sv
add_exec.sv
adder_cluster_top.sv
tb_adder_cluster.sv

// ==== Makefile ====
VERILATOR  = verilator
FLAGS      = --binary --timing --assert -j 0
LINT_FLAGS = --lint-only --timing --assert
TOP        = tb_adder_cluster
FLIST      = flist.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_adder_cluster.sv ====
`timescale 1ns/1ps

module tb_adder_cluster import lau_pkg::*; ();

	localparam int     width   = 16;
	localparam speed_e speed   = FAST;
	localparam int     credits = 4;
	localparam int     n_rand  = 40;           // random requests per client
	localparam int     stim_w  = 2*width + 3;  // op, a, b, cin

	logic              clk;
	logic              arst_n;
	logic [1:0]        req_valid;
	op_e               req_op [2];
	logic [width-1:0]  req_a [2];
	logic [width-1:0]  req_b [2];
	logic [1:0]        req_cin;
	logic [1:0]        credit;
	logic [1:0]        rsp_valid;
	logic [width-1:0]  rsp_sum;
	logic              rsp_cout;

	logic [stim_w-1:0] stim [2][$];      // requests not yet sent
	logic [width:0]    expect_q [2][$];  // {cout, sum} in issue order
	int                held [2];         // credits each client holds
	int                pulses [2];       // credit pulses seen
	int                sent [2];         // requests the dut sampled
	int                sent_d1 [2];      // sent as of the previous edge
	int                done_cnt [2];     // responses seen
	int                last_port;        // owner of last cycle's response or -1
	int                cycles;
	int                cycle_limit;
	int                seed;
	bit                running;

	initial clk = 1'b0;
	always #20 clk = ~clk;  // 40 ns period

	adder_cluster_top #(.width(width), .speed(speed), .credits(credits)) dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.req_valid_0(req_valid[0]),
		.req_op_0   (req_op[0]),
		.req_a_0    (req_a[0]),
		.req_b_0    (req_b[0]),
		.req_cin_0  (req_cin[0]),
		.credit_0   (credit[0]),
		.req_valid_1(req_valid[1]),
		.req_op_1   (req_op[1]),
		.req_a_1    (req_a[1]),
		.req_b_1    (req_b[1]),
		.req_cin_1  (req_cin[1]),
		.credit_1   (credit[1]),
		.rsp_valid_0(rsp_valid[0]),
		.rsp_valid_1(rsp_valid[1]),
		.rsp_sum    (rsp_sum),
		.rsp_cout   (rsp_cout)
	);

	task automatic stop_run(input string msg);
		$display("%s", msg);
		$display("Finished with errors");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string msg);
		stop_run($sformatf("error at %0t ns: %s", $time, msg));
	endtask

	// expected {cout, sum} straight from the operation rules
	function automatic logic [width:0] expected_result(input op_e op,
			input logic [width-1:0] a, input logic [width-1:0] b, input logic cin);
		logic [width:0] r;
		case (op)
			OP_ADD:  r = {1'b0, a} + {1'b0, b};
			OP_ADDC: r = {1'b0, a} + {1'b0, b} + {{width{1'b0}}, cin};
			OP_SUB: begin
				r[width-1:0] = a - b;   // wraps mod 2**width
				r[width]     = (a >= b);  // no borrow
			end
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic add_request(input int p, input op_e op, input logic [width-1:0] a,
			input logic [width-1:0] b, input logic cin);
		stim[p].push_back({op, a, b, cin});
	endtask

	task automatic load_directed(input int p);
		logic [width-1:0] ones;
		logic [width-1:0] r;
		ones = '1;
		r    = width'($random(seed));
		add_request(p, OP_ADD, ones, width'(1), 1'b1);   // wraps and ignores cin
		add_request(p, OP_ADD, '0, '0, 1'b0);
		add_request(p, OP_ADD, ones, ones, 1'b0);
		add_request(p, OP_SUB, r, r, 1'b0);               // equal operands
		add_request(p, OP_SUB, '0, '0, 1'b0);
		add_request(p, OP_SUB, '0, width'(1), 1'b0);      // borrow all the way
		add_request(p, OP_SUB, width'(5), width'(9), 1'b0);
		add_request(p, OP_SUB, ones, width'(1), 1'b0);
		add_request(p, OP_ADDC, ones, ones, 1'b1);
		add_request(p, OP_ADDC, ones, '0, 1'b1);          // carry-in ripples full width
		add_request(p, OP_ADDC, '0, '0, 1'b1);
		add_request(p, OP_ADDC, r, ~r, 1'b0);
	endtask

	task automatic load_random(input int p);
		logic [width-1:0] a;
		logic [width-1:0] b;
		op_e              op;
		for (int i = 0; i < n_rand; i++) begin
			op = op_e'(2'({$random(seed)} % 3));
			a  = width'($random(seed));
			b  = (i % 8 == 0) ? a : width'($random(seed));  // some equal pairs
			add_request(p, op, a, b, 1'($random(seed)));
		end
	endtask

	// quiet outputs in reset and at the release edge
	reset_quiet: assert property (@(posedge clk)
		(!arst_n || $rose(arst_n)) |-> (credit == 2'b00 && rsp_valid == 2'b00))
		else stop_run("credit or response went high during reset");

	rsp_one_port: assert property (@(posedge clk) disable iff (!arst_n)
		!(rsp_valid[0] && rsp_valid[1]))
		else stop_run("both ports got a response in the same cycle");

	always @(posedge clk) begin : client_model
		logic [width:0]    exp_val;
		logic [stim_w-1:0] s;
		int                prev_port;
		if (running) begin
			prev_port = last_port;
			last_port = -1;
			for (int p = 0; p < 2; p++) begin
				if (credit[p]) begin
					held[p]++;
					pulses[p]++;
				end
				assert (held[p] <= credits)
					else stop_run($sformatf("client %0d holds more credits than it started with", p));
				if (rsp_valid[p]) begin
					assert (expect_q[p].size() != 0)
						else stop_run($sformatf("port %0d got a response it never asked for", p));
					exp_val = expect_q[p].pop_front();
					assert ({rsp_cout, rsp_sum} == exp_val)
						else value_error($sformatf("port %0d sum %h cout %b, expected sum %h cout %b",
							p, rsp_sum, rsp_cout, exp_val[width-1:0], exp_val[width]));
					// other head was valid at grant time yet this port won again
					assert (prev_port != p || sent_d1[1-p] == done_cnt[1-p])
						else stop_run($sformatf("port %0d served twice in a row while the other waited", p));
					done_cnt[p]++;
					last_port = p;
				end
			end
			for (int p = 0; p < 2; p++) begin
				sent_d1[p] = sent[p];
				if (req_valid[p])
					sent[p]++;  // dut took it at this edge
				if (held[p] > 0 && stim[p].size() != 0) begin
					s = stim[p].pop_front();
					req_valid[p] <= 1'b1;
					req_op[p]    <= op_e'(s[stim_w-1 -: 2]);
					req_a[p]     <= s[2*width:width+1];
					req_b[p]     <= s[width:1];
					req_cin[p]   <= s[0];
					expect_q[p].push_back(expected_result(op_e'(s[stim_w-1 -: 2]),
						s[2*width:width+1], s[width:1], s[0]));
					held[p]--;  // spend one credit
				end else begin
					req_valid[p] <= 1'b0;
				end
			end
		end
	end

	initial begin : run_test
		int total;
		seed      = 32'hf97f8f13;
		arst_n    <= 1'b0;
		req_valid <= '0;
		req_cin   <= '0;
		running   <= 1'b0;
		last_port = -1;
		cycles    = 0;
		for (int p = 0; p < 2; p++) begin
			req_op[p]   <= OP_ADD;
			req_a[p]    <= '0;
			req_b[p]    <= '0;
			held[p]     = credits;
			pulses[p]   = 0;
			sent[p]     = 0;
			sent_d1[p]  = 0;
			done_cnt[p] = 0;
			load_directed(p);
			load_random(p);
		end
		total       = stim[0].size() + stim[1].size();
		cycle_limit = 20*total + 100;
		repeat (2) @(posedge clk);
		arst_n  <= 1'b1;
		running <= 1'b1;
		// wait until every request is sent and answered
		while (stim[0].size() + stim[1].size() + expect_q[0].size() + expect_q[1].size() != 0)
		begin
			@(negedge clk);
			cycles++;
			if (cycles > cycle_limit)
				stop_run($sformatf("timeout, traffic still outstanding after %0d cycles", cycles));
		end
		// last credit pulse comes in the same cycle as the last response
		if (held[0] == credits && held[1] == credits
				&& pulses[0] == sent[0] && pulses[1] == sent[1]) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			stop_run($sformatf("credits not all returned, held %0d and %0d, pulses %0d and %0d for %0d and %0d requests",
				held[0], held[1], pulses[0], pulses[1], sent[0], sent[1]));
		end
	end

endmodule

// ==== adder_cluster_top.sv ====
`timescale 1ns/1ps

module adder_cluster_top import lau_pkg::*; #(
	parameter int     width   = 16,    // operand width
	parameter speed_e speed   = FAST,  // prefix structure
	parameter int     credits = 4      // per-client queue depth
) (
	input  logic             clk,
	input  logic             arst_n,
	// client 0
	input  logic             req_valid_0,
	input  op_e              req_op_0,
	input  logic [width-1:0] req_a_0,
	input  logic [width-1:0] req_b_0,
	input  logic             req_cin_0,
	output logic             credit_0,
	// client 1
	input  logic             req_valid_1,
	input  op_e              req_op_1,
	input  logic [width-1:0] req_a_1,
	input  logic [width-1:0] req_b_1,
	input  logic             req_cin_1,
	output logic             credit_1,
	// responses share sum and cout
	output logic             rsp_valid_0,
	output logic             rsp_valid_1,
	output logic [width-1:0] rsp_sum,
	output logic             rsp_cout
);

	logic                    head_valid_0, head_valid_1;
	op_e                     head_op_0, head_op_1;
	logic [width-1:0]        head_a_0, head_a_1;
	logic [width-1:0]        head_b_0, head_b_1;
	logic                    head_cin_0, head_cin_1;
	logic [1:0]              grant;      // also the pop per port
	logic [log2floor(2)-1:0] sel;        // granted port
	logic [1:0]              rsp_valid;

	req_port #(.width(width), .credits(credits)) u_port_0 (
		.clk       (clk),          .arst_n    (arst_n),
		.req_valid (req_valid_0),  .req_op    (req_op_0),
		.req_a     (req_a_0),      .req_b     (req_b_0),
		.req_cin   (req_cin_0),    .pop       (grant[0]),
		.head_valid(head_valid_0), .head_op   (head_op_0),
		.head_a    (head_a_0),     .head_b    (head_b_0),
		.head_cin  (head_cin_0),   .credit    (credit_0)
	);

	req_port #(.width(width), .credits(credits)) u_port_1 (
		.clk       (clk),          .arst_n    (arst_n),
		.req_valid (req_valid_1),  .req_op    (req_op_1),
		.req_a     (req_a_1),      .req_b     (req_b_1),
		.req_cin   (req_cin_1),    .pop       (grant[1]),
		.head_valid(head_valid_1), .head_op   (head_op_1),
		.head_a    (head_a_1),     .head_b    (head_b_1),
		.head_cin  (head_cin_1),   .credit    (credit_1)
	);

	rr_arbiter u_arb (
		.clk      (clk),
		.arst_n   (arst_n),
		.req      ({head_valid_1, head_valid_0}),
		.grant    (grant),
		.grant_idx(sel)
	);

	// granted head into the shared stage
	add_exec #(.width(width), .speed(speed)) u_exec (
		.clk      (clk),
		.arst_n   (arst_n),
		.valid    (|grant),
		.op       (sel[0] ? head_op_1  : head_op_0),
		.a        (sel[0] ? head_a_1   : head_a_0),
		.b        (sel[0] ? head_b_1   : head_b_0),
		.cin      (sel[0] ? head_cin_1 : head_cin_0),
		.idx      (sel[0]),
		.rsp_valid(rsp_valid),
		.rsp_sum  (rsp_sum),
		.rsp_cout (rsp_cout)
	);

	assign rsp_valid_0 = rsp_valid[0];
	assign rsp_valid_1 = rsp_valid[1];

endmodule

// ==== add_exec.sv ====
`timescale 1ns/1ps

module add_exec import lau_pkg::*; #(
	parameter int     width = 16,   // operand width
	parameter speed_e speed = FAST  // prefix structure of the adder
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             valid,      // a head was granted
	input  op_e              op,
	input  logic [width-1:0] a,
	input  logic [width-1:0] b,
	input  logic             cin,
	input  logic             idx,        // owning port
	output logic [1:0]       rsp_valid,  // one bit per port
	output logic [width-1:0] rsp_sum,    // shared between ports
	output logic             rsp_cout
);

	logic [width-1:0] b_op;  // second operand after decode
	logic             c_op;  // carry in after decode
	logic [width-1:0] sum;
	logic             cout;

	always_comb begin
		b_op = b;
		c_op = 1'b0;
		case (op)
			OP_ADD:  c_op = 1'b0;
			OP_ADDC: c_op = cin;   // request carry
			OP_SUB: begin
				b_op = ~b;         // two's complement
				c_op = 1'b1;
			end
			default: c_op = 1'b0;
		endcase
	end

	add_cfast #(
		.width(width),
		.speed(speed)
	) u_add (
		.a   (a),
		.b   (b_op),
		.cin (c_op),
		.sum (sum),
		.cout(cout)
	);

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rsp_valid <= '0;
		end else begin
			rsp_valid <= '0;  // single cycle pulse
			if (valid)
				rsp_valid[idx] <= 1'b1;
		end
	end

	// payload, qualified by rsp_valid
	always_ff @(posedge clk) begin
		if (valid) begin
			rsp_sum  <= sum;
			rsp_cout <= cout;
		end
	end

	a_op_known: assert property (@(posedge clk) disable iff (!arst_n)
		valid |-> !$isunknown(op))
		else $error("add_exec unknown opcode on a granted request");

endmodule

// ==== rr_arbiter.sv ====
`timescale 1ns/1ps

// two-way round robin with a combinational grant
module rr_arbiter import lau_pkg::*; (
	input  logic                       clk,
	input  logic                       arst_n,
	input  logic [1:0]                 req,       // head valid per port
	output logic [1:0]                 grant,     // one-hot or zero
	output logic [log2floor(2)-1:0]    grant_idx  // index of the granted port
);

	logic prio;  // port that wins a tie

	always_comb begin
		grant = '0;
		if (req[prio])
			grant[prio] = 1'b1;
		else if (req[~prio])
			grant[~prio] = 1'b1;  // other port takes the idle slot
	end

	assign grant_idx = grant[1];

	// last winner drops to low priority
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			prio <= 1'b0;  // port 0 first after reset
		else if (|grant)
			prio <= ~grant_idx;
	end

	a_grant_legal: assert property (@(posedge clk) disable iff (!arst_n)
		$onehot0(grant) && ((grant & ~req) == 2'b00))
		else $error("rr_arbiter grant not one-hot or to an idle port");

endmodule

// ==== req_port.sv ====
`timescale 1ns/1ps

module req_port import lau_pkg::*; #(
	parameter int width   = 16,  // operand width
	parameter int credits = 4    // queue depth = starting credits
) (
	input  logic             clk,
	input  logic             arst_n,
	input  logic             req_valid,  // costs the client one credit
	input  op_e              req_op,
	input  logic [width-1:0] req_a,
	input  logic [width-1:0] req_b,
	input  logic             req_cin,
	input  logic             pop,        // head granted
	output logic             head_valid,
	output op_e              head_op,
	output logic [width-1:0] head_a,
	output logic [width-1:0] head_b,
	output logic             head_cin,
	output logic             credit      // one credit back
);

	localparam int ew = 2*width + 3;                          // op, a, b, cin
	localparam int aw = (credits > 1) ? $clog2(credits) : 1;  // pointer bits
	localparam int cw = $clog2(credits + 1);                  // fill count bits

	logic [ew-1:0] mem [credits];  // entry storage
	logic [ew-1:0] head;
	logic [aw-1:0] wr_ptr;
	logic [aw-1:0] rd_ptr;
	logic [cw-1:0] count;          // entries held
	logic          full;

	// wrap at depth, depth need not be a power of two
	function automatic logic [aw-1:0] next_ptr(input logic [aw-1:0] p);
		if (p == aw'(credits - 1))
			return '0;
		return p + aw'(1);
	endfunction

	assign full       = (count == cw'(credits));
	assign head_valid = (count != '0);
	assign head       = mem[rd_ptr];
	assign head_op    = op_e'(head[ew-1 -: 2]);
	assign head_a     = head[2*width:width+1];
	assign head_b     = head[width:1];
	assign head_cin   = head[0];

	always_ff @(posedge clk) begin
		if (req_valid)
			mem[wr_ptr] <= {req_op, req_a, req_b, req_cin};
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
			credit <= 1'b0;
		end else begin
			if (req_valid)
				wr_ptr <= next_ptr(wr_ptr);
			if (pop)
				rd_ptr <= next_ptr(rd_ptr);
			case ({req_valid, pop})
				2'b10:   count <= count + cw'(1);
				2'b01:   count <= count - cw'(1);
				default: count <= count;  // idle or push and pop together
			endcase
			credit <= pop;  // registered return, cycle after the pop
		end
	end

	// client overdrew its credits
	a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n)
		req_valid |-> !full)
		else $error("req_port push while full, credit overdraw");

	// arbiter only grants a live head
	a_pop_valid: assert property (@(posedge clk) disable iff (!arst_n)
		pop |-> head_valid)
		else $error("req_port pop from empty queue");

endmodule

// ==== add_cfast.sv ====
`timescale 1ns/1ps

// {cout, sum} = a + b + cin over a prefix carry tree
module add_cfast import lau_pkg::*; #(
	parameter int     width = 16,   // word width
	parameter speed_e speed = FAST  // prefix structure
) (
	input  logic [width-1:0] a,     // operands
	input  logic [width-1:0] b,
	input  logic             cin,   // carry in
	output logic [width-1:0] sum,
	output logic             cout
);

	logic [width-1:0] gi;  // bit generate
	logic [width-1:0] pi;  // bit propagate, or form
	logic [width-1:0] hs;  // half sum
	logic [width-1:0] go;  // carries out of each bit

	assign gi = a & b;
	assign pi = a | b;
	assign hs = a ^ b;

	prefix_and_or #(
		.width(width),
		.speed(speed)
	) u_prefix (
		.gi (gi),
		.pi (pi),
		.cin(cin),
		.go (go),
		.po ()   // group propagate not needed here
	);

	// carry into bit i is the carry out of bit i-1
	assign sum  = hs ^ {go[width-2:0], cin};
	assign cout = go[width-1];

endmodule

// ==== prefix_and_or.sv ====
`timescale 1ns/1ps

module prefix_and_or import lau_pkg::*; #(
	parameter int     width = 16,   // word width
	parameter speed_e speed = FAST  // prefix structure
) (
	input  logic [width-1:0] gi,   // bit generate
	input  logic [width-1:0] pi,   // bit propagate
	input  logic             cin,  // fast carry in
	output logic [width-1:0] go,   // group generate, carry in folded
	output logic [width-1:0] po    // group propagate
);

	localparam int n = width;
	localparam int m = (width > 1) ? $clog2(width) : 1;  // tree depth

	logic [n-1:0] gt_out;  // prefix generate before carry-in level
	logic [n-1:0] pt_out;  // prefix propagate

	if (speed == FAST) begin : g_sklansky
		logic [m:0][n-1:0] gt;
		logic [m:0][n-1:0] pt;

		assign gt[0] = gi;
		assign pt[0] = pi;

		for (genvar l = 1; l <= m; l++) begin : g_level
			for (genvar j = 0; j < n; j++) begin : g_bit
				// upper half of each 2**l block
				if (((j >> (l-1)) % 2) == 1) begin : g_black
					// top bit of the lower half feeds the whole upper half
					localparam int src = ((j >> l) << l) + 2**(l-1) - 1;
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j];  // pass through
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		assign gt_out = gt[m];
		assign pt_out = pt[m];
	end else if (speed == MEDIUM) begin : g_brent_kung
		localparam int nl = 2*m;  // input level plus up and down sweep

		logic [nl-1:0][n-1:0] gt;
		logic [nl-1:0][n-1:0] pt;

		assign gt[0] = gi;
		assign pt[0] = pi;

		for (genvar l = 1; l < nl; l++) begin : g_level
			localparam bit up = (l <= m);                  // reduction half
			localparam int s  = up ? 2**l : 2**(nl - l);   // node span
			for (genvar j = 0; j < n; j++) begin : g_bit
				if (up ? ((j+1) % s == 0) : (j >= s && (j+1) % s == s/2)) begin : g_black
					localparam int src = j - s/2;  // left neighbour group
					assign gt[l][j] = gt[l-1][j] | (pt[l-1][j] & gt[l-1][src]);
					assign pt[l][j] = pt[l-1][j] & pt[l-1][src];
				end else begin : g_white
					assign gt[l][j] = gt[l-1][j];
					assign pt[l][j] = pt[l-1][j];
				end
			end
		end

		assign gt_out = gt[nl-1];
		assign pt_out = pt[nl-1];
	end else begin : g_serial
		logic [n-1:0] gt;
		logic [n-1:0] pt;

		// ripple chain, one node per bit
		assign gt[0] = gi[0];
		assign pt[0] = pi[0];

		for (genvar j = 1; j < n; j++) begin : g_bit
			assign gt[j] = gi[j] | (pi[j] & gt[j-1]);
			assign pt[j] = pi[j] & pt[j-1];
		end

		assign gt_out = gt;
		assign pt_out = pt;
	end

	// extra level for the late carry in
	assign go = gt_out | (pt_out & {width{cin}});
	assign po = pt_out;

endmodule

// ==== lau_pkg.sv ====
package lau_pkg;

	// prefix structure, trades depth for area
	typedef enum logic [1:0] {
		SLOW   = 2'b00,  // serial chain
		MEDIUM = 2'b01,  // brent-kung
		FAST   = 2'b10   // sklansky
	} speed_e;

	// arithmetic request codes
	typedef enum logic [1:0] {
		OP_ADD  = 2'b00,  // a + b
		OP_ADDC = 2'b01,  // a + b + cin
		OP_SUB  = 2'b10   // a + ~b + 1
	} op_e;

	// floor of log2, n must be positive
	function automatic int log2floor(input int n);
		int m;
		int p;
		m = -1;
		p = 1;
		while (p <= n) begin
			m = m + 1;
			p = p * 2;  // next power of two
		end
		return m;
	endfunction

endpackage
